/* build.f */
+incdir+hdl
hdl/arcade_pkg.sv
hdl/mem_req_if.sv
hdl/mem_ch3_arbiter.sv
hdl/hiscore_mem_bridge.sv
hdl/dip_switch_bank.sv
hdl/player_input_merge.sv
hdl/arcade_glue_top.sv
tb/tb_arcade_glue.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_arcade_glue
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_arcade_glue.sv */
////////////////////
// Directed testbench for the arcade glue top level
// Memory model with random ready delay, check tasks,
// cycle timeout
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "arcade_defs.svh"

module tb_arcade_glue;
    import arcade_pkg::*;

    // Tests take a few hundred cycles at most
    localparam int TIMEOUT_CYCLES = 2000;

    logic      clk_sys;
    logic      rst_n;
    logic      dl_download;
    logic      dl_wr;
    logic [7:0] dl_index;
    mem_addr_t dl_addr;
    logic [7:0] dl_data;
    mem_addr_t rom_addr;
    mem_word_u rom_wdata;
    mem_be_t   rom_be;
    logic      rom_req;
    logic      rdy;
    hs_addr_t  hs_address;
    logic [7:0] hs_data_in;
    logic      hs_write_en;
    logic      hs_read_en;
    logic [7:0] hs_data_out;
    logic      hs_data_ready;
    mem_addr_t cpu_addr;
    mem_word_u cpu_wdata;
    mem_be_t   cpu_be;
    logic      cpu_req;
    mem_word_u cpu_rdata;
    mem_addr_t mem_addr;
    mem_word_u mem_wdata;
    mem_be_t   mem_be;
    logic      mem_rnw;
    logic      mem_req;
    mem_word_u mem_rdata;
    logic      mem_rdy;
    pad_word_t joy_p1;
    pad_word_t joy_p2;
    pad_word_t joy_p3;
    pad_word_t joy_p4;
    pad_word_t key_p1;
    pad_word_t key_p2;
    pad_word_t key_p3;
    pad_word_t key_p4;
    logic [3:0] key_start;
    logic [3:0] key_coin;
    logic      key_pause;
    player_t   p1_input;
    player_t   p2_input;
    player_t   p3_input;
    player_t   p4_input;
    logic [3:0] start_buttons;
    logic [3:0] coin;
    logic      pause;
    dip_word_t dip_sw;

    // Memory model state
    mem_word_u   mem_array [0:65535];
    mem_word_u   wr_word;
    logic [15:0] pend_index;
    int          rdy_wait = 0;
    int          req_count = 0;
    int          ready_count = 0;
    int          cycle_count = 0;
    mem_addr_t   last_addr;
    mem_word_u   last_wdata;
    mem_be_t     last_be;
    logic        last_rnw;

    arcade_glue_top dut_i (.*);

    always #10 clk_sys = ~clk_sys;

    ////////////////////
    // Memory model
    ////////////////////
    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            mem_rdy  <= 1'b0;
            rdy_wait <= 0;
        end else begin
            mem_rdy <= 1'b0;
            if (hs_data_ready) begin
                ready_count <= ready_count + 1;
            end
            if (rdy_wait != 0) begin
                rdy_wait <= rdy_wait - 1;
                if (rdy_wait == 1) begin
                    mem_rdy   <= 1'b1;
                    mem_rdata <= mem_array[pend_index];
                end
            end else if (mem_req) begin
                last_addr  <= mem_addr;
                last_wdata <= mem_wdata;
                last_be    <= mem_be;
                last_rnw   <= mem_rnw;
                pend_index <= mem_addr[16:1];
                req_count  <= req_count + 1;
                rdy_wait   <= $urandom_range(6, 1);
                // Writes land in the array when the request is taken
                if (!mem_rnw) begin
                    wr_word = mem_array[mem_addr[16:1]];
                    if (mem_be[1]) wr_word.bytes.hi = mem_wdata.bytes.hi;
                    if (mem_be[0]) wr_word.bytes.lo = mem_wdata.bytes.lo;
                    mem_array[mem_addr[16:1]] <= wr_word;
                end
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////
    // Check tasks
    ////////////////////
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("TB FAILED");
        $fatal(1, "Value mismatch on %s", name);
    endtask

    task automatic check_word(input string name, input mem_word_u got, input mem_word_u exp);
        if (got !== exp) report_mismatch(name, 32'(got.word), 32'(exp.word));
    endtask

    task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_be(input string name, input mem_be_t got, input mem_be_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_dip(input string name, input dip_word_t got, input dip_word_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_player(input string name, input player_t got, input player_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bits4(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic wait_data_ready();
        do begin
            @(negedge clk_sys);
        end while (hs_data_ready !== 1'b1);
    endtask

    task automatic wait_mem_idle();
        while (rdy_wait != 0 || mem_rdy) @(negedge clk_sys);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic check_after_reset();
        @(negedge clk_sys);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("hs_data_ready", hs_data_ready, 1'b0);
        check_dip("dip_sw", dip_sw, 24'hFFFFFF);
        check_player("p1_input", p1_input, '0);
        check_player("p2_input", p2_input, '0);
        check_player("p3_input", p3_input, '0);
        check_player("p4_input", p4_input, '0);
        check_bits4("start_buttons", start_buttons, 4'h0);
        check_bits4("coin", coin, 4'h0);
        check_bit("pause", pause, 1'b0);
    endtask

    task automatic test_channel_priority();
        mem_addr_t cpu_a;
        mem_word_u exp_cpu;
        cpu_a   = 25'h1ABCDE;
        exp_cpu = mem_array[cpu_a[16:1]];
        // CPU write replaces the low byte
        exp_cpu.bytes.lo = 8'h34;
        // ROM download owns the channel even with a CPU request pending
        @(posedge clk_sys);
        dl_download <= 1'b1;
        dl_index    <= `ROM_DL_INDEX;
        rom_addr    <= 25'h0123456;
        rom_wdata   <= 16'hBEEF;
        rom_be      <= 2'b00;
        rom_req     <= 1'b1;
        cpu_addr    <= cpu_a;
        cpu_wdata   <= 16'h1234;
        cpu_be      <= 2'b01;
        cpu_req     <= 1'b1;
        @(negedge clk_sys);
        check_addr("mem_addr", mem_addr, 25'h0123456);
        check_word("mem_wdata", mem_wdata, 16'hBEEF);
        check_be("mem_be", mem_be, 2'b00);
        // ROM stream writes even with no lane enabled
        check_bit("mem_rnw", mem_rnw, 1'b0);
        check_bit("mem_req", mem_req, 1'b1);
        @(posedge clk_sys);
        rom_req <= 1'b0;
        @(negedge clk_sys);
        check_bit("mem_req", mem_req, 1'b0);
        wait_mem_idle();
        @(posedge clk_sys);
        dl_download <= 1'b0;
        @(negedge clk_sys);
        check_addr("mem_addr", mem_addr, cpu_a);
        check_word("mem_wdata", mem_wdata, 16'h1234);
        check_be("mem_be", mem_be, 2'b01);
        check_bit("mem_rnw", mem_rnw, 1'b0);
        check_bit("mem_req", mem_req, 1'b1);
        @(posedge clk_sys);
        cpu_req <= 1'b0;
        cpu_be  <= 2'b00;
        @(negedge clk_sys);
        check_bit("mem_rnw", mem_rnw, 1'b1);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("rdy", rdy, 1'b0);
        // Ready and read data fan back to the CPU side
        while (rdy !== 1'b1) @(negedge clk_sys);
        check_word("cpu_rdata", cpu_rdata, exp_cpu);
        wait_mem_idle();
    endtask

    task automatic test_hs_write(input hs_addr_t addr, input logic [7:0] data);
        mem_addr_t full;
        mem_word_u exp_word;
        int        req_base;
        int        ready_base;
        full       = {`CPU_RAM_BASE_HI, addr[15:0]};
        exp_word   = mem_array[full[16:1]];
        req_base   = req_count;
        ready_base = ready_count;
        if (addr[0]) exp_word.bytes.hi = data;
        else exp_word.bytes.lo = data;
        @(posedge clk_sys);
        hs_address  <= addr;
        hs_data_in  <= data;
        hs_write_en <= 1'b1;
        wait_data_ready();
        @(posedge clk_sys);
        hs_write_en <= 1'b0;
        @(negedge clk_sys);
        check_bit("hs_data_ready", hs_data_ready, 1'b0);
        check_byte("request count", 8'(req_count - req_base), 8'd1);
        check_byte("hs_data_ready count", 8'(ready_count - ready_base), 8'd1);
        check_addr("mem_addr", last_addr, full);
        check_be("mem_be", last_be, addr[0] ? 2'b10 : 2'b01);
        check_word("mem_wdata", last_wdata, {data, data});
        check_bit("mem_rnw", last_rnw, 1'b0);
        check_word("memory word", mem_array[full[16:1]], exp_word);
    endtask

    task automatic test_hs_read(input hs_addr_t addr, input mem_word_u word);
        mem_addr_t full;
        int        req_base;
        int        ready_base;
        full       = {`CPU_RAM_BASE_HI, addr[15:0]};
        req_base   = req_count;
        ready_base = ready_count;
        mem_array[full[16:1]] = word;
        @(posedge clk_sys);
        hs_address <= addr;
        hs_read_en <= 1'b1;
        wait_data_ready();
        check_byte("hs_data_out", hs_data_out, addr[0] ? word.bytes.hi : word.bytes.lo);
        // A held strobe must not start a second access
        repeat (4) @(posedge clk_sys);
        hs_read_en <= 1'b0;
        @(negedge clk_sys);
        check_byte("request count", 8'(req_count - req_base), 8'd1);
        check_byte("hs_data_ready count", 8'(ready_count - ready_base), 8'd1);
        check_addr("mem_addr", last_addr, full);
        check_be("mem_be", last_be, 2'b00);
        check_bit("mem_rnw", last_rnw, 1'b1);
    endtask

    task automatic dip_write(input logic [7:0] index, input mem_addr_t addr,
                             input logic [7:0] data);
        @(posedge clk_sys);
        dl_wr    <= 1'b1;
        dl_index <= index;
        dl_addr  <= addr;
        dl_data  <= data;
        @(posedge clk_sys);
        dl_wr <= 1'b0;
        @(negedge clk_sys);
    endtask

    task automatic test_dip_capture();
        dip_word_t exp;
        exp = 24'hFFFFFF;
        dip_write(`DIP_DL_INDEX, 25'd0, 8'h12);
        exp[0] = 8'h12;
        check_dip("dip_sw", dip_sw, exp);
        dip_write(`DIP_DL_INDEX, 25'd1, 8'h34);
        exp[1] = 8'h34;
        check_dip("dip_sw", dip_sw, exp);
        dip_write(`DIP_DL_INDEX, 25'd2, 8'h56);
        exp[2] = 8'h56;
        check_dip("dip_sw", dip_sw, exp);
        // Wrong index, then an address past the bank
        dip_write(8'd3, 25'd0, 8'h00);
        check_dip("dip_sw", dip_sw, exp);
        dip_write(`DIP_DL_INDEX, 25'd8, 8'h00);
        check_dip("dip_sw", dip_sw, exp);
    endtask

    task automatic test_input_merge(input int rounds);
        pad_word_t  jv [4];
        pad_word_t  kv [4];
        pad_word_t  joy_or;
        logic [3:0] ks;
        logic [3:0] kc;
        logic       kp;
        logic [3:0] exp_start;
        for (int r = 0; r < rounds; r++) begin
            // Sparse control bits so both levels show up
            for (int n = 0; n < 4; n++) begin
                jv[n] = 16'($urandom) & 16'($urandom) & 16'($urandom);
                kv[n] = 16'($urandom) & 16'($urandom);
            end
            ks = 4'($urandom) & 4'($urandom) & 4'($urandom);
            kc = 4'($urandom) & 4'($urandom) & 4'($urandom);
            kp = 1'($urandom) & 1'($urandom);
            @(posedge clk_sys);
            joy_p1    <= jv[0];
            joy_p2    <= jv[1];
            joy_p3    <= jv[2];
            joy_p4    <= jv[3];
            key_p1    <= kv[0];
            key_p2    <= kv[1];
            key_p3    <= kv[2];
            key_p4    <= kv[3];
            key_start <= ks;
            key_coin  <= kc;
            key_pause <= kp;
            @(posedge clk_sys);
            @(negedge clk_sys);
            joy_or = jv[0] | jv[1] | jv[2] | jv[3];
            for (int n = 0; n < 4; n++) begin
                exp_start[n] = jv[n][`JOY_START] | ks[n];
            end
            exp_start[1] = exp_start[1] | joy_or[`JOY_ALT_START];
            check_player("p1_input", p1_input, player_t'(jv[0] | kv[0]));
            check_player("p2_input", p2_input, player_t'(jv[1] | kv[1]));
            check_player("p3_input", p3_input, player_t'(jv[2] | kv[2]));
            check_player("p4_input", p4_input, player_t'(jv[3] | kv[3]));
            check_bits4("start_buttons", start_buttons, exp_start);
            check_bits4("coin", coin, {3'b000, joy_or[`JOY_COIN] | (|kc)});
            check_bit("pause", pause, joy_or[`JOY_PAUSE] | kp);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        void'($urandom(69));
        clk_sys     = 1'b0;
        rst_n       = 1'b0;
        dl_download = 1'b0;
        dl_wr       = 1'b0;
        dl_index    = 8'd0;
        dl_addr     = '0;
        dl_data     = 8'd0;
        rom_addr    = '0;
        rom_wdata   = '0;
        rom_be      = 2'b00;
        rom_req     = 1'b0;
        hs_address  = '0;
        hs_data_in  = 8'd0;
        hs_write_en = 1'b0;
        hs_read_en  = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_be      = 2'b00;
        cpu_req     = 1'b0;
        mem_rdata   = '0;
        mem_rdy     = 1'b0;
        joy_p1      = '0;
        joy_p2      = '0;
        joy_p3      = '0;
        joy_p4      = '0;
        key_p1      = '0;
        key_p2      = '0;
        key_p3      = '0;
        key_p4      = '0;
        key_start   = 4'h0;
        key_coin    = 4'h0;
        key_pause   = 1'b0;
        // Fill differs for every word address
        for (int i = 0; i < 65536; i++) begin
            mem_array[i] = 16'(i * 16'h9E37 + 16'h5A5A);
        end
        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;
        check_after_reset();
        test_channel_priority();
        test_hs_write(20'h01234, 8'h5C);
        test_hs_write(20'h01235, 8'hA7);
        test_hs_read(20'h00042, 16'hC3E1);
        test_hs_read(20'h00043, 16'hC3E1);
        test_dip_capture();
        test_input_merge(24);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/arcade_glue_top.sv */
////////////////////
// Board glue top level: channel arbiter, high-score
// bridge, DIP bank and input merge
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "arcade_defs.svh"

module arcade_glue_top (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    // Download stream
    input  wire                        dl_download,
    input  wire                        dl_wr,
    input  wire [7:0]                  dl_index,
    input  wire arcade_pkg::mem_addr_t dl_addr,
    input  wire [7:0]                  dl_data,
    // ROM loader requests
    input  wire arcade_pkg::mem_addr_t rom_addr,
    input  wire arcade_pkg::mem_word_u rom_wdata,
    input  wire arcade_pkg::mem_be_t   rom_be,
    input  wire                        rom_req,
    output wire                        rdy,
    // High-score engine
    input  wire arcade_pkg::hs_addr_t  hs_address,
    input  wire [7:0]                  hs_data_in,
    input  wire                        hs_write_en,
    input  wire                        hs_read_en,
    output wire [7:0]                  hs_data_out,
    output wire                        hs_data_ready,
    // Game CPU
    input  wire arcade_pkg::mem_addr_t cpu_addr,
    input  wire arcade_pkg::mem_word_u cpu_wdata,
    input  wire arcade_pkg::mem_be_t   cpu_be,
    input  wire                        cpu_req,
    output wire arcade_pkg::mem_word_u cpu_rdata,
    // External memory channel
    output wire arcade_pkg::mem_addr_t mem_addr,
    output wire arcade_pkg::mem_word_u mem_wdata,
    output wire arcade_pkg::mem_be_t   mem_be,
    output wire                        mem_rnw,
    output wire                        mem_req,
    input  wire arcade_pkg::mem_word_u mem_rdata,
    input  wire                        mem_rdy,
    // Controls
    input  wire arcade_pkg::pad_word_t joy_p1,
    input  wire arcade_pkg::pad_word_t joy_p2,
    input  wire arcade_pkg::pad_word_t joy_p3,
    input  wire arcade_pkg::pad_word_t joy_p4,
    input  wire arcade_pkg::pad_word_t key_p1,
    input  wire arcade_pkg::pad_word_t key_p2,
    input  wire arcade_pkg::pad_word_t key_p3,
    input  wire arcade_pkg::pad_word_t key_p4,
    input  wire [3:0]                  key_start,
    input  wire [3:0]                  key_coin,
    input  wire                        key_pause,
    output wire arcade_pkg::player_t   p1_input,
    output wire arcade_pkg::player_t   p2_input,
    output wire arcade_pkg::player_t   p3_input,
    output wire arcade_pkg::player_t   p4_input,
    output wire [3:0]                  start_buttons,
    output wire [3:0]                  coin,
    output wire                        pause,
    output wire arcade_pkg::dip_word_t dip_sw
);
    import arcade_pkg::*;

    // ROM stream owns the channel for the whole download
    wire rom_write = dl_download && (dl_index == `ROM_DL_INDEX);

    mem_req_if hs_bus ();

    mem_ch3_arbiter arbiter_i (
        .clk_sys, .rst_n,
        .rom_write, .rom_addr, .rom_wdata, .rom_be, .rom_req,
        .hs         (hs_bus),
        .cpu_addr, .cpu_wdata, .cpu_be, .cpu_req,
        .mem_addr, .mem_wdata, .mem_be, .mem_rnw, .mem_req,
        .mem_rdata, .mem_rdy, .cpu_rdata, .rdy
    );

    hiscore_mem_bridge hs_bridge_i (
        .clk_sys, .rst_n,
        .hs_address, .hs_data_in, .hs_write_en, .hs_read_en,
        .hs_data_out, .hs_data_ready,
        .mem        (hs_bus)
    );

    dip_switch_bank dip_i (
        .clk_sys, .rst_n,
        .dl_wr, .dl_index, .dl_addr, .dl_data,
        .dip_sw
    );

    player_input_merge inputs_i (
        .clk_sys, .rst_n,
        .joy_p1, .joy_p2, .joy_p3, .joy_p4,
        .key_p1, .key_p2, .key_p3, .key_p4,
        .key_start, .key_coin, .key_pause,
        .p1_input, .p2_input, .p3_input, .p4_input,
        .start_buttons, .coin, .pause
    );

endmodule

`default_nettype wire

/* hdl/player_input_merge.sv */
////////////////////
// Keyboard and joystick merge into player inputs,
// start, coin and pause
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "arcade_defs.svh"

module player_input_merge (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    input  wire arcade_pkg::pad_word_t joy_p1,
    input  wire arcade_pkg::pad_word_t joy_p2,
    input  wire arcade_pkg::pad_word_t joy_p3,
    input  wire arcade_pkg::pad_word_t joy_p4,
    input  wire arcade_pkg::pad_word_t key_p1,
    input  wire arcade_pkg::pad_word_t key_p2,
    input  wire arcade_pkg::pad_word_t key_p3,
    input  wire arcade_pkg::pad_word_t key_p4,
    input  wire [3:0]                  key_start,
    input  wire [3:0]                  key_coin,
    input  wire                        key_pause,
    output arcade_pkg::player_t        p1_input,
    output arcade_pkg::player_t        p2_input,
    output arcade_pkg::player_t        p3_input,
    output arcade_pkg::player_t        p4_input,
    output logic [3:0]                 start_buttons,
    output logic [3:0]                 coin,
    output logic                       pause
);
    import arcade_pkg::*;

    pad_word_t merged_p1;
    pad_word_t merged_p2;
    pad_word_t merged_p3;
    pad_word_t merged_p4;
    pad_word_t joy_any;

    assign merged_p1 = joy_p1 | key_p1;
    assign merged_p2 = joy_p2 | key_p2;
    assign merged_p3 = joy_p3 | key_p3;
    assign merged_p4 = joy_p4 | key_p4;
    // Shared controls accept any joystick
    assign joy_any   = joy_p1 | joy_p2 | joy_p3 | joy_p4;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            p1_input      <= '0;
            p2_input      <= '0;
            p3_input      <= '0;
            p4_input      <= '0;
            start_buttons <= '0;
            coin          <= '0;
            pause         <= 1'b0;
        end else begin
            p1_input      <= merged_p1[`PLAYER_W-1:0];
            p2_input      <= merged_p2[`PLAYER_W-1:0];
            p3_input      <= merged_p3[`PLAYER_W-1:0];
            p4_input      <= merged_p4[`PLAYER_W-1:0];
            start_buttons <= {joy_p4[`JOY_START] | key_start[3],
                              joy_p3[`JOY_START] | key_start[2],
                              joy_p2[`JOY_START] | joy_any[`JOY_ALT_START] | key_start[1],
                              joy_p1[`JOY_START] | key_start[0]};
            // Single coin slot
            coin          <= {3'b000, joy_any[`JOY_COIN] | (|key_coin)};
            pause         <= joy_any[`JOY_PAUSE] | key_pause;
        end
    end

endmodule

`default_nettype wire

/* hdl/dip_switch_bank.sv */
////////////////////
// DIP switch bytes captured from the download stream
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "arcade_defs.svh"

module dip_switch_bank (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    input  wire                        dl_wr,
    input  wire [7:0]                  dl_index,
    input  wire arcade_pkg::mem_addr_t dl_addr,
    input  wire [7:0]                  dl_data,
    output arcade_pkg::dip_word_t      dip_sw
);
    import arcade_pkg::*;

    // Active low switches, all off out of reset
    logic [7:0] dip_bytes [`DIP_BYTES];
    logic       dip_hit;

    assign dip_hit = dl_wr && (dl_index == `DIP_DL_INDEX) && !(|dl_addr[`MEM_ADDR_W-1:3]);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DIP_BYTES; i++) begin
                dip_bytes[i] <= 8'hFF;
            end
        end else if (dip_hit) begin
            dip_bytes[dl_addr[2:0]] <= dl_data;
        end
    end

    // The game sees the first three bytes only
    assign dip_sw = {dip_bytes[2], dip_bytes[1], dip_bytes[0]};

endmodule

`default_nettype wire

/* hdl/hiscore_mem_bridge.sv */
////////////////////
// High-score byte strobes to shared channel
// word requests, with byte lane selection
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "arcade_defs.svh"

module hiscore_mem_bridge (
    input  wire                       clk_sys,
    input  wire                       rst_n,
    input  wire arcade_pkg::hs_addr_t hs_address,
    input  wire [7:0]                 hs_data_in,
    input  wire                       hs_write_en,
    input  wire                       hs_read_en,
    output logic [7:0]                hs_data_out,
    output logic                      hs_data_ready,
    mem_req_if.requester              mem
);
    import arcade_pkg::*;

    logic write_lat;
    logic read_lat;
    logic start;
    logic done;

    // New access on a strobe edge, only when idle
    assign start = !mem.active &&
                   ((hs_write_en && !write_lat) || (hs_read_en && !read_lat));

    // A rdy in the issue cycle belongs to an earlier access
    assign done = mem.active && mem.rdy && !mem.req;

    ////////////////////
    // Request control
    ////////////////////
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            write_lat     <= 1'b0;
            read_lat      <= 1'b0;
            mem.be        <= '0;
            mem.req       <= 1'b0;
            mem.active    <= 1'b0;
            hs_data_ready <= 1'b0;
        end else begin
            write_lat     <= hs_write_en;
            read_lat      <= hs_read_en;
            mem.req       <= start;
            hs_data_ready <= done;
            if (start) begin
                mem.active <= 1'b1;
                // Odd byte address goes to the high lane
                mem.be <= hs_write_en ? {hs_address[0], ~hs_address[0]} : 2'b00;
            end else if (done) begin
                mem.active <= 1'b0;
            end
        end
    end

    ////////////////////
    // Address and data
    ////////////////////
    always_ff @(posedge clk_sys) begin
        if (start) begin
            mem.addr <= {`CPU_RAM_BASE_HI, hs_address[15:0]};
            if (hs_write_en) begin
                mem.wdata.bytes.hi <= hs_data_in;
                mem.wdata.bytes.lo <= hs_data_in;
            end
        end
        if (done) begin
            hs_data_out <= mem.addr[0] ? mem.rdata.bytes.hi : mem.rdata.bytes.lo;
        end
    end

    a_no_req_while_active: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        mem.req |-> !$past(mem.active)
    );

    a_ready_single: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        hs_data_ready |=> !hs_data_ready
    );

endmodule

`default_nettype wire

/* hdl/mem_ch3_arbiter.sv */
////////////////////
// Fixed-priority selection of the shared channel
// ROM download, then high score, then CPU
////////////////////
`timescale 1ns/100ps
`default_nettype none

module mem_ch3_arbiter (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    input  wire                        rom_write,
    input  wire arcade_pkg::mem_addr_t rom_addr,
    input  wire arcade_pkg::mem_word_u rom_wdata,
    input  wire arcade_pkg::mem_be_t   rom_be,
    input  wire                        rom_req,
    mem_req_if.arbiter                 hs,
    input  wire arcade_pkg::mem_addr_t cpu_addr,
    input  wire arcade_pkg::mem_word_u cpu_wdata,
    input  wire arcade_pkg::mem_be_t   cpu_be,
    input  wire                        cpu_req,
    output arcade_pkg::mem_addr_t      mem_addr,
    output arcade_pkg::mem_word_u      mem_wdata,
    output arcade_pkg::mem_be_t        mem_be,
    output logic                       mem_rnw,
    output logic                       mem_req,
    input  wire arcade_pkg::mem_word_u mem_rdata,
    input  wire                        mem_rdy,
    output arcade_pkg::mem_word_u      cpu_rdata,
    output logic                       rdy
);
    import arcade_pkg::*;

    // ROM writes never read back, others read when no lane is enabled
    always_comb begin
        if (rom_write) begin
            mem_addr  = rom_addr;
            mem_wdata = rom_wdata;
            mem_be    = rom_be;
            mem_rnw   = 1'b0;
            mem_req   = rom_req;
        end else if (hs.active) begin
            mem_addr  = hs.addr;
            mem_wdata = hs.wdata;
            mem_be    = hs.be;
            mem_rnw   = ~(|hs.be);
            mem_req   = hs.req;
        end else begin
            mem_addr  = cpu_addr;
            mem_wdata = cpu_wdata;
            mem_be    = cpu_be;
            mem_rnw   = ~(|cpu_be);
            mem_req   = cpu_req;
        end
    end

    // Completion and read data go back to every requester
    assign hs.rdata  = mem_rdata;
    assign hs.rdy    = mem_rdy;
    assign cpu_rdata = mem_rdata;
    assign rdy       = mem_rdy;

    // Direction must be known when the memory sees a new request
    a_req_be_known: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $rose(mem_req) |-> !$isunknown(mem_be)
    );

endmodule

`default_nettype wire

/* hdl/mem_req_if.sv */
////////////////////
// One requester's access on the shared channel
////////////////////
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if;
    import arcade_pkg::*;

    mem_addr_t addr;
    mem_word_u wdata;
    mem_be_t   be;
    // One-cycle pulse, counted while active holds
    logic      req;
    // High from the request until completion
    logic      active;
    mem_word_u rdata;
    logic      rdy;

    modport requester (output addr, wdata, be, req, active, input rdata, rdy);
    modport arbiter (input addr, wdata, be, req, active, output rdata, rdy);

endinterface

`default_nettype wire

/* hdl/arcade_pkg.sv */
////////////////////
// Shared types: channel address, byte enables,
// channel word union, player and DIP words
////////////////////
`default_nettype none

`include "arcade_defs.svh"

package arcade_pkg;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // Bit 1 enables the high byte
    typedef logic [1:0] mem_be_t;

    typedef struct packed {
        logic [`MEM_DATA_W/2-1:0] hi;
        logic [`MEM_DATA_W/2-1:0] lo;
    } mem_bytes_t;

    // One channel word, seen whole or as two byte lanes
    typedef union packed {
        logic [`MEM_DATA_W-1:0] word;
        mem_bytes_t             bytes;
    } mem_word_u;

    typedef logic [`HS_ADDR_W-1:0] hs_addr_t;
    typedef logic [15:0]           pad_word_t;
    typedef logic [`PLAYER_W-1:0]  player_t;
    typedef logic [2:0][7:0]       dip_word_t;

endpackage

`default_nettype wire

/* hdl/arcade_defs.svh */
////////////////////
// Widths, download indices, joystick bit positions
// and the CPU work-RAM base for the arcade glue
////////////////////
`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// Shared memory channel
`define MEM_ADDR_W      25
`define MEM_DATA_W      16
`define HS_ADDR_W       20
// Upper 9 byte-address bits of the CPU work RAM
`define CPU_RAM_BASE_HI 9'h100

// Download stream indices
`define ROM_DL_INDEX    8'd0
`define DIP_DL_INDEX    8'd254
`define DIP_BYTES       8

// Player inputs and joystick control bits
`define PLAYER_W        10
`define JOY_START       10
`define JOY_COIN        11
`define JOY_ALT_START   12
`define JOY_PAUSE       13

`endif
